// File: Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_bus_port.sv
  - rv_decode.sv
  - rv_regfile.sv
  - rv_alu.sv
  - rv_control.sv
  - rv_datapath.sv
  - rv_core.sv
  - target: simulation
    files:
      - core_properties.sv
      - tb_checker.sv
      - tb_core.sv

// File: compile.f
rv_pkg.sv
rv_bus_port.sv
rv_decode.sv
rv_regfile.sv
rv_alu.sv
rv_control.sv
rv_datapath.sv
rv_core.sv
core_properties.sv
tb_checker.sv
tb_core.sv

// File: core_properties.sv
////////////////////////////////////////////////////////////
// bus strobe and reset assertions, bound into rv_core
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module core_properties (
	input logic          clk,
	input logic          rst,
	input logic          ready,
	input logic          rd,
	input logic          we,
	input rv_pkg::word_t a,
	input rv_pkg::word_t d
);

	int n_fail = 0;

	// one direction at a time
	strobe_excl: assert property (@(posedge clk) !(rd && we))
		else begin
			$error("rd and we high in the same cycle");
			n_fail++;
		end

	// address and write data held until ready
	addr_hold: assert property (@(posedge clk) disable iff (rst)
		(rd || we) && !ready |=> $stable(a) && (rd || we))
		else begin
			$error("bus address or strobe changed before ready");
			n_fail++;
		end

	wdata_hold: assert property (@(posedge clk) disable iff (rst)
		we && !ready |=> $stable(d))
		else begin
			$error("write data changed before ready");
			n_fail++;
		end

	quiet_in_reset: assert property (@(posedge clk) rst |-> !rd && !we)
		else begin
			$error("bus strobe active during reset");
			n_fail++;
		end

endmodule

bind rv_core core_properties props (.*);

// File: core_tests.txt
// kind (1 program, 2 data in bus order, 3 expected stores in bus order), base, count, words
// program words are plain instructions; expected store i of a record is at base + 4*i
1 000 8 12300093 FF900113 002081B3 30302023 40208233 30402223 001112B3 30502423
1 020 8 40115313 30602623 001153B3 30702823 00112433 30802A23 001134B3 30902C23
1 040 8 0F00C513 30A02E23 0020E5B3 32B02023 0F017613 32C02223 40000693 00068703
1 060 8 32E02423 00168703 32E02623 00268703 32E02823 00368703 32E02A23 0006C703
1 080 8 32E02C23 00069703 32E02E23 00269703 34E02023 0026D703 34E02223 05500793
// branch pairs: taken skips a bad store, not taken falls into a marker store
1 0A0 8 3AD00813 00108463 35002423 00208463 34F02423 00209463 35002623 00109463
1 0C0 8 34F02623 00114463 35002823 0020C463 34F02823 0020D463 35002A23 00115463
1 0E0 8 34F02A23 0020E463 35002C23 00116463 34F02C23 00117463 35002E23 0020F463
// jal, jalr to an odd target, then lui, fence, auipc and a spin loop
1 100 8 34F02E23 008008EF 37002023 37102023 11D009E7 37002223 37002223 37302223
1 120 6 ABCDEA37 0FF0000F 12345A97 37402423 37502623 0000006F
2 400 1 857A34C6
3 300 8 1C010000 2A010000 C8FFFFFF FCFFFFFF FFFFFF1F 01000000 00000000 D3010000
3 320 8 FBFFFFFF F0000000 85FFFFFF 7A000000 34000000 C6FFFFFF 85000000 857A0000
3 340 8 34C6FFFF 34C60000 55000000 55000000 55000000 55000000 55000000 55000000
3 360 4 08010000 14010000 00E0CDAB 28513412
0

// File: rv_alu.sv
////////////////////////////////////////////////////////////
// RV32I integer ALU, purely combinational
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rv_alu (
	input  rv_pkg::alu_op_e op,
	input  rv_pkg::word_t   x,
	input  rv_pkg::word_t   y,
	output rv_pkg::word_t   res
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = y[4:0];
	assign lt_s = $signed(x) < $signed(y);
	assign lt_u = x < y;

	always_comb begin
		case (op)
			rv_pkg::alu_add:  res = x + y;
			rv_pkg::alu_sub:  res = x - y;
			rv_pkg::alu_sll:  res = x << shamt;
			rv_pkg::alu_slt:  res = {31'b0, lt_s};
			rv_pkg::alu_sltu: res = {31'b0, lt_u};
			rv_pkg::alu_xor:  res = x ^ y;
			rv_pkg::alu_srl:  res = x >> shamt;
			// arithmetic shift keeps the sign bit
			rv_pkg::alu_sra:  res = $signed(x) >>> shamt;
			rv_pkg::alu_or:   res = x | y;
			rv_pkg::alu_and:  res = x & y;
			default:          res = x + y;
		endcase
	end

endmodule

// File: rv_bus_port.sv
////////////////////////////////////////////////////////////
// bus side of the core: aligned address, byte swap, read word
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rv_bus_port (
	input  logic             clk,
	input  logic             rst,
	input  rv_pkg::mem_req_t req,
	input  rv_pkg::word_t    spo,
	input  logic             ready,
	output rv_pkg::word_t    a,
	output rv_pkg::word_t    d,
	output logic             rd,
	output logic             we,
	output rv_pkg::word_t    mdr
);

	// bus words carry byte 0 in the top lane
	function automatic rv_pkg::word_t swap(input rv_pkg::word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	assign a = {req.addr[31:2], 2'b00};
	assign d = swap(req.wdata);

	// bus stays quiet while the core is held in reset
	assign rd = req.rd && !rst;
	assign we = req.we && !rst;

	// read word kept for decode or load alignment
	always_ff @(posedge clk) begin
		if (ready && req.rd) begin
			mdr <= swap(spo);
		end
	end

endmodule

// File: rv_control.sv
////////////////////////////////////////////////////////////
// phase sequencer, drives the datapath control struct
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rv_control (
	input  logic             clk,
	input  logic             rst,
	input  rv_pkg::decoded_t dec,
	input  logic             ready,
	input  logic             br_taken,
	output rv_pkg::ctrl_t    ctrl
);

	rv_pkg::phase_e phase;
	rv_pkg::phase_e phase_n;
	logic           is_load;
	logic           is_store;
	logic           take;

	assign is_load = dec.opcode == rv_pkg::op_load;
	assign is_store = dec.opcode == rv_pkg::op_store;

	// beq, bge and bgeu are taken on a zero compare result
	assign take = (dec.funct3[2] ? dec.funct3[0] : !dec.funct3[0]) ^ br_taken;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= rv_pkg::ph_fetch;
		end else begin
			phase <= phase_n;
		end
	end

	always_comb begin
		phase_n = phase;
		case (phase)
			rv_pkg::ph_fetch: if (ready) phase_n = rv_pkg::ph_decode;
			rv_pkg::ph_decode: begin
				case (dec.opcode)
					rv_pkg::op_lui, rv_pkg::op_auipc, rv_pkg::op_jal:
						phase_n = rv_pkg::ph_writeback;
					// fence and anything unknown retire as no-ops
					rv_pkg::op_fence, rv_pkg::op_bad: phase_n = rv_pkg::ph_fetch;
					default: phase_n = rv_pkg::ph_execute;
				endcase
			end
			rv_pkg::ph_execute:
				phase_n = (is_load || is_store) ? rv_pkg::ph_memory : rv_pkg::ph_writeback;
			rv_pkg::ph_memory:
				if (ready) phase_n = is_load ? rv_pkg::ph_writeback : rv_pkg::ph_fetch;
			default: phase_n = rv_pkg::ph_fetch;
		endcase
	end

	always_comb begin
		ctrl = '0;
		// later phases keep the execute operands so the result register holds
		ctrl.a_src = rv_pkg::a_rs1;
		ctrl.b_src = (dec.opcode == rv_pkg::op_reg || dec.opcode == rv_pkg::op_branch)
			? rv_pkg::b_rs2 : rv_pkg::b_imm;
		ctrl.alu_op = dec.alu_op;
		case (phase)
			rv_pkg::ph_fetch: begin
				ctrl.mem_rd = 1'b1;
				ctrl.ir_write = 1'b1;
			end
			rv_pkg::ph_decode: begin
				// pc-relative target while pc still points at this instruction
				ctrl.pc_write = 1'b1;
				ctrl.a_src = rv_pkg::a_pc;
				ctrl.b_src = rv_pkg::b_imm;
				ctrl.alu_op = rv_pkg::alu_add;
			end
			rv_pkg::ph_memory: begin
				ctrl.addr_is_data = 1'b1;
				ctrl.mem_rd = is_load;
				ctrl.mem_we = is_store;
			end
			rv_pkg::ph_writeback: begin
				case (dec.opcode)
					rv_pkg::op_lui: ctrl.wb_src = rv_pkg::wb_imm;
					rv_pkg::op_load: ctrl.wb_src = rv_pkg::wb_load;
					rv_pkg::op_jal, rv_pkg::op_jalr: ctrl.wb_src = rv_pkg::wb_link;
					default: ctrl.wb_src = rv_pkg::wb_alu;
				endcase
				ctrl.reg_write = dec.opcode != rv_pkg::op_branch;
				if (dec.opcode == rv_pkg::op_jal) begin
					ctrl.pc_write = 1'b1;
					ctrl.pc_src = rv_pkg::pc_jump;
				end else if (dec.opcode == rv_pkg::op_jalr) begin
					ctrl.pc_write = 1'b1;
					ctrl.pc_src = rv_pkg::pc_jump_clr;
				end else if (dec.opcode == rv_pkg::op_branch) begin
					ctrl.pc_write = take;
					ctrl.pc_src = rv_pkg::pc_branch;
				end
			end
			default: ;
		endcase
	end

endmodule

// File: rv_core.sv
////////////////////////////////////////////////////////////
// multicycle RV32I core top, one shared memory port
// start_addr gives the pc after reset
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rv_core #(
	parameter rv_pkg::word_t start_addr = 32'h0000_0000
) (
	input  logic          clk,
	input  logic          rst,
	input  rv_pkg::word_t spo,
	input  logic          ready,
	output rv_pkg::word_t a,
	output rv_pkg::word_t d,
	output logic          rd,
	output logic          we
);

	rv_pkg::mem_req_t req;
	rv_pkg::word_t    mdr;
	rv_pkg::word_t    ir;
	rv_pkg::decoded_t dec;
	rv_pkg::ctrl_t    ctrl;
	logic             br_taken;

	rv_bus_port u_bus_port (
		.clk(clk), .rst(rst), .req(req), .spo(spo), .ready(ready),
		.a(a), .d(d), .rd(rd), .we(we), .mdr(mdr)
	);

	rv_decode u_decode (.ir(ir), .dec(dec));

	rv_control u_control (
		.clk(clk), .rst(rst), .dec(dec), .ready(ready),
		.br_taken(br_taken), .ctrl(ctrl)
	);

	rv_datapath #(.start_addr(start_addr)) u_datapath (
		.clk(clk), .rst(rst), .ctrl(ctrl), .dec(dec), .mdr(mdr),
		.ir(ir), .br_taken(br_taken), .req(req)
	);

endmodule

// File: rv_datapath.sv
////////////////////////////////////////////////////////////
// pc, ir and operand registers, muxes, load alignment
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rv_datapath #(
	parameter rv_pkg::word_t start_addr = 32'h0000_0000
) (
	input  logic             clk,
	input  logic             rst,
	input  rv_pkg::ctrl_t    ctrl,
	input  rv_pkg::decoded_t dec,
	input  rv_pkg::word_t    mdr,
	output rv_pkg::word_t    ir,
	output logic             br_taken,
	output rv_pkg::mem_req_t req
);

	rv_pkg::word_t pc;
	rv_pkg::word_t pc_n;
	rv_pkg::word_t ir_q;
	logic          ir_pend;
	rv_pkg::word_t a_q;
	rv_pkg::word_t b_q;
	rv_pkg::word_t alu_q;
	rv_pkg::word_t alu_q2;
	rv_pkg::word_t rs1_val;
	rv_pkg::word_t rs2_val;
	rv_pkg::word_t alu_x;
	rv_pkg::word_t alu_y;
	rv_pkg::word_t alu_res;
	rv_pkg::word_t wb_data;
	rv_pkg::word_t load_data;
	logic [7:0]    ld_byte;
	logic [15:0]   ld_half;

	rv_regfile u_regfile (
		.clk(clk), .ra0(dec.rs1), .ra1(dec.rs2), .wa(dec.rd),
		.we(ctrl.reg_write), .wd(wb_data), .rd0(rs1_val), .rd1(rs2_val)
	);

	rv_alu u_alu (.op(ctrl.alu_op), .x(alu_x), .y(alu_y), .res(alu_res));

	// fetched word sits in mdr during decode, then moves into ir_q
	assign ir = ir_pend ? mdr : ir_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= start_addr;
			ir_pend <= 1'b0;
		end else begin
			ir_pend <= ctrl.ir_write;
			if (ctrl.pc_write) pc <= pc_n;
		end
	end

	always_ff @(posedge clk) begin
		if (ir_pend) ir_q <= mdr;
		a_q <= rs1_val;
		b_q <= rs2_val;
		alu_q <= alu_res;
		// one step older result holds the branch target
		alu_q2 <= alu_q;
	end

	always_comb begin
		case (ctrl.pc_src)
			rv_pkg::pc_branch: pc_n = alu_q2;
			rv_pkg::pc_jump: pc_n = alu_q;
			rv_pkg::pc_jump_clr: pc_n = {alu_q[31:1], 1'b0};
			default: pc_n = pc + 32'd4;
		endcase
	end

	assign alu_x = (ctrl.a_src == rv_pkg::a_pc) ? pc : a_q;
	assign alu_y = (ctrl.b_src == rv_pkg::b_imm) ? dec.imm : b_q;
	assign br_taken = |alu_q;

	// byte lane picked by the low address bits
	assign ld_byte = mdr[8*alu_q[1:0] +: 8];
	assign ld_half = alu_q[1] ? mdr[31:16] : mdr[15:0];

	always_comb begin
		case (dec.funct3[1:0])
			2'b00: load_data = {{24{ld_byte[7] & !dec.funct3[2]}}, ld_byte};
			2'b01: load_data = {{16{ld_half[15] & !dec.funct3[2]}}, ld_half};
			default: load_data = mdr;
		endcase
	end

	always_comb begin
		case (ctrl.wb_src)
			rv_pkg::wb_imm: wb_data = dec.imm;
			rv_pkg::wb_link: wb_data = pc;
			rv_pkg::wb_load: wb_data = load_data;
			default: wb_data = alu_q;
		endcase
	end

	assign req.addr = ctrl.addr_is_data ? alu_q : pc;
	assign req.wdata = b_q;
	assign req.rd = ctrl.mem_rd;
	assign req.we = ctrl.mem_we;

endmodule

// File: rv_decode.sv
////////////////////////////////////////////////////////////
// instruction decode: fields, immediate and ALU function
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rv_decode (
	input  rv_pkg::word_t    ir,
	output rv_pkg::decoded_t dec
);

	rv_pkg::opcode_e opc;
	logic [2:0]      f3;

	assign f3 = ir[14:12];

	always_comb begin
		case (ir[6:0])
			rv_pkg::op_lui, rv_pkg::op_auipc, rv_pkg::op_jal, rv_pkg::op_jalr,
			rv_pkg::op_branch, rv_pkg::op_load, rv_pkg::op_store,
			rv_pkg::op_imm, rv_pkg::op_reg, rv_pkg::op_fence:
				opc = rv_pkg::opcode_e'(ir[6:0]);
			default: opc = rv_pkg::op_bad;
		endcase
	end

	assign dec.opcode = opc;
	assign dec.funct3 = f3;
	assign dec.rs1 = ir[19:15];
	assign dec.rs2 = ir[24:20];
	assign dec.rd = ir[11:7];

	// immediate format follows the opcode
	always_comb begin
		case (opc)
			rv_pkg::op_lui, rv_pkg::op_auipc: dec.imm = {ir[31:12], 12'b0};
			rv_pkg::op_jal:
				dec.imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
			rv_pkg::op_branch:
				dec.imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
			rv_pkg::op_store: dec.imm = {{21{ir[31]}}, ir[30:25], ir[11:7]};
			rv_pkg::op_jalr, rv_pkg::op_load, rv_pkg::op_imm:
				dec.imm = {{21{ir[31]}}, ir[30:20]};
			default: dec.imm = '0;
		endcase
	end

	always_comb begin
		dec.alu_op = rv_pkg::alu_add;
		if (opc == rv_pkg::op_reg || opc == rv_pkg::op_imm) begin
			case (f3)
				// sub only exists in the register form
				3'b000: dec.alu_op = (opc == rv_pkg::op_reg && ir[30]) ? rv_pkg::alu_sub
					: rv_pkg::alu_add;
				3'b001: dec.alu_op = rv_pkg::alu_sll;
				3'b010: dec.alu_op = rv_pkg::alu_slt;
				3'b011: dec.alu_op = rv_pkg::alu_sltu;
				3'b100: dec.alu_op = rv_pkg::alu_xor;
				3'b101: dec.alu_op = ir[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
				3'b110: dec.alu_op = rv_pkg::alu_or;
				default: dec.alu_op = rv_pkg::alu_and;
			endcase
		end else if (opc == rv_pkg::op_branch) begin
			// eq/ne compare by subtraction, the rest by set-less-than
			if (f3[2]) begin
				dec.alu_op = f3[1] ? rv_pkg::alu_sltu : rv_pkg::alu_slt;
			end else begin
				dec.alu_op = rv_pkg::alu_sub;
			end
		end
	end

endmodule

// File: rv_pkg.sv
////////////////////////////////////////////////////////////
// shared widths, enums and structs of the multicycle core
////////////////////////////////////////////////////////////
package rv_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// major opcodes as found in ir[6:0]
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011,
		op_fence  = 7'b0001111,
		op_bad    = 7'b0000000
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		alu_xor, alu_srl, alu_sra, alu_or, alu_and
	} alu_op_e;

	typedef enum logic [2:0] {
		ph_fetch, ph_decode, ph_execute, ph_memory, ph_writeback
	} phase_e;

	typedef enum logic [1:0] {pc_plus4, pc_branch, pc_jump, pc_jump_clr} pc_src_e;
	typedef enum logic {a_rs1, a_pc} a_src_e;
	typedef enum logic {b_rs2, b_imm} b_src_e;
	typedef enum logic [1:0] {wb_alu, wb_imm, wb_link, wb_load} wb_src_e;

	typedef struct packed {
		opcode_e    opcode;
		logic [2:0] funct3;
		reg_addr_t  rs1;
		reg_addr_t  rs2;
		reg_addr_t  rd;
		word_t      imm;
		alu_op_e    alu_op;
	} decoded_t;

	typedef struct packed {
		logic    pc_write;
		pc_src_e pc_src;
		logic    ir_write;
		logic    addr_is_data;
		a_src_e  a_src;
		b_src_e  b_src;
		alu_op_e alu_op;
		logic    reg_write;
		wb_src_e wb_src;
		logic    mem_rd;
		logic    mem_we;
	} ctrl_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic  rd;
		logic  we;
	} mem_req_t;

endpackage

// File: rv_regfile.sv
////////////////////////////////////////////////////////////
// integer register file, two reads and one write
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rv_regfile (
	input  logic              clk,
	input  rv_pkg::reg_addr_t ra0,
	input  rv_pkg::reg_addr_t ra1,
	input  rv_pkg::reg_addr_t wa,
	input  logic              we,
	input  rv_pkg::word_t     wd,
	output rv_pkg::word_t     rd0,
	output rv_pkg::word_t     rd1
);

	rv_pkg::word_t regs [32];

	// x0 is never stored
	always_ff @(posedge clk) begin
		if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	assign rd0 = (ra0 == 5'd0) ? '0 : regs[ra0];
	assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];

endmodule

// File: tb_checker.sv
////////////////////////////////////////////////////////////
// watches bus transfers and compares stores with the
// expected list, one result line per check
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_checker (
	input  logic          clk,
	input  logic          rst,
	input  logic          ready,
	input  logic          rd,
	input  logic          we,
	input  rv_pkg::word_t a,
	input  rv_pkg::word_t d,
	output logic          done,
	output int            n_ok,
	output int            n_err
);

	rv_pkg::word_t exp_addr [$];
	rv_pkg::word_t exp_data [$];
	logic          first_rd_seen;
	int            n_store;

	initial begin
		done = 1'b0;
		n_ok = 0;
		n_err = 0;
		first_rd_seen = 1'b0;
		n_store = 0;
	end

	task automatic add_expect(input rv_pkg::word_t addr, input rv_pkg::word_t data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	always @(posedge clk) begin
		if (!rst && ready && rd && !first_rd_seen) begin
			first_rd_seen = 1'b1;
			if (a != 32'h0) begin
				$display("ERR %0t: first fetch at %h, expected 00000000", $time, a);
				n_err++;
			end else begin
				$display("first fetch at 00000000 ok");
				n_ok++;
			end
		end
		if (!rst && ready && we) begin
			if (exp_addr.size() == 0) begin
				$display("unexpected store to %h after all expected stores", a);
				n_err++;
			end else if (a != exp_addr[0] || d != exp_data[0]) begin
				$display("ERR %0t: store %0d at %h data %h, expected %h data %h",
					$time, n_store, a, d, exp_addr[0], exp_data[0]);
				n_err++;
			end else begin
				$display("store %0d at %h data %h ok", n_store, a, d);
				n_ok++;
			end
			if (exp_addr.size() != 0) begin
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
				n_store++;
				if (exp_addr.size() == 0) done <= 1'b1;
			end
		end
	end

endmodule

// File: tb_core.sv
////////////////////////////////////////////////////////////
// core testbench: memory model loaded from core_tests.txt,
// random wait states, checker and watchdog
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_core;

	logic          clk;
	logic          rst;
	logic          ready;
	logic          rd;
	logic          we;
	rv_pkg::word_t spo;
	rv_pkg::word_t a;
	rv_pkg::word_t d;
	logic          done;
	int            n_ok;
	int            n_err;

	logic [31:0]   tests [0:255];
	rv_pkg::word_t mem [logic [31:0]];
	logic [31:0]   lfsr;
	logic          busy;
	logic [1:0]    wait_left;
	int            n_prog;
	logic          loaded;

	rv_core #(.start_addr(32'h0000_0000)) dut (.*);

	tb_checker chk (
		.clk(clk), .rst(rst), .ready(ready), .rd(rd), .we(we), .a(a), .d(d),
		.done(done), .n_ok(n_ok), .n_err(n_err)
	);

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// instructions are written little-endian, the bus carries byte 0 on top
	function automatic rv_pkg::word_t bus_order(input rv_pkg::word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic rv_pkg::word_t read_word(input rv_pkg::word_t addr);
		return mem.exists(addr >> 2) ? mem[addr >> 2] : 32'h0;
	endfunction

	// records: kind, base address, word count, words
	task automatic load_tests();
		int          idx;
		int          i;
		logic [31:0] kind;
		logic [31:0] base;
		logic [31:0] cnt;
		for (idx = 0; idx < 256; idx++) tests[idx] = 32'h0;
		$readmemh("core_tests.txt", tests);
		idx = 0;
		while (idx < 253 && tests[idx] != 32'h0) begin
			kind = tests[idx];
			base = tests[idx + 1];
			cnt = tests[idx + 2];
			for (i = 0; i < cnt; i++) begin
				case (kind)
					32'd1: begin
						mem[(base >> 2) + i] = bus_order(tests[idx + 3 + i]);
						n_prog++;
					end
					32'd2: mem[(base >> 2) + i] = tests[idx + 3 + i];
					default: chk.add_expect(base + 4 * i, tests[idx + 3 + i]);
				endcase
			end
			idx += 3 + cnt;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// memory answers after 1 to 4 cycles of strobe
	always @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
			busy = 1'b0;
		end else if (ready) begin
			ready <= 1'b0;
			busy = 1'b0;
			if (we) mem[a >> 2] = d;
		end else if (rd || we) begin
			if (!busy) begin
				busy = 1'b1;
				lfsr = lfsr_next(lfsr);
				wait_left[0] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				wait_left[1] = lfsr[0];
			end
			if (wait_left == 2'd0) begin
				ready <= 1'b1;
				spo <= rd ? read_word(a) : 32'h0;
			end else begin
				wait_left--;
			end
		end
	end

	initial begin
		rst = 1'b1;
		spo = 32'h0;
		ready = 1'b0;
		lfsr = 32'h4212f2a2;
		busy = 1'b0;
		wait_left = 2'd0;
		n_prog = 0;
		loaded = 1'b0;
		load_tests();
		loaded = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		wait (done);
		// the spin loop keeps running, any further store counts as an error
		repeat (100) @(negedge clk);
		$display("checks: %0d ok, %0d failed, %0d assertion failures",
			n_ok, n_err, dut.props.n_fail);
		if (n_err == 0 && dut.props.n_fail == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// about 8 cycles per program word plus slack
	initial begin
		wait (loaded);
		#(n_prog * 64 + 8000);
		$display("timeout: the program never produced all expected stores");
		$display("TEST FAIL");
		$finish;
	end

endmodule
